/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    localparam logic [ADDR_W-1:0] RST_VECTOR = 16'hfffc; // low byte of the start address

    // opcode byte as seen by the decoder
    typedef struct packed {
        logic [2:0] aaa; // operation
        logic [2:0] bbb; // addressing mode
        logic [1:0] cc;  // group
    } opcode_fields_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        opcode_fields_t    f;
    } opcode_u;

    // single byte opcodes and jmp, matched on the raw byte
    localparam logic [DATA_W-1:0] OP_JMP_ABS = 8'h4c;
    localparam logic [DATA_W-1:0] OP_TAX     = 8'haa;
    localparam logic [DATA_W-1:0] OP_TXA     = 8'h8a;
    localparam logic [DATA_W-1:0] OP_INX     = 8'he8;
    localparam logic [DATA_W-1:0] OP_DEX     = 8'hca;
    localparam logic [DATA_W-1:0] OP_CLC     = 8'h18;
    localparam logic [DATA_W-1:0] OP_SEC     = 8'h38;
    localparam logic [DATA_W-1:0] OP_NOP     = 8'hea;

    // field values for the two decoded groups
    localparam logic [1:0] CC_ALU    = 2'b01;
    localparam logic [1:0] CC_X      = 2'b10; // ldx and stx
    localparam logic [2:0] BBB_IMM_X = 3'b000;
    localparam logic [2:0] BBB_ZPG   = 3'b001;
    localparam logic [2:0] BBB_IMM   = 3'b010;
    localparam logic [2:0] BBB_ABS   = 3'b011;
    localparam logic [2:0] AAA_ORA   = 3'b000;
    localparam logic [2:0] AAA_AND   = 3'b001;
    localparam logic [2:0] AAA_EOR   = 3'b010;
    localparam logic [2:0] AAA_ADC   = 3'b011;
    localparam logic [2:0] AAA_ST    = 3'b100;
    localparam logic [2:0] AAA_LD    = 3'b101;
    localparam logic [2:0] AAA_SBC   = 3'b111;

    localparam int MODE_W = 3;
    localparam logic [MODE_W-1:0] MODE_IMP = 3'd0;
    localparam logic [MODE_W-1:0] MODE_IMM = 3'd1;
    localparam logic [MODE_W-1:0] MODE_ZPG = 3'd2;
    localparam logic [MODE_W-1:0] MODE_ABS = 3'd3;
    localparam logic [MODE_W-1:0] MODE_JMP = 3'd4;
    localparam logic [MODE_W-1:0] MODE_BAD = 3'd7;

    localparam int ALU_OP_W = 2;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 2'd0;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 2'd1;
    localparam logic [ALU_OP_W-1:0] ALU_ORA = 2'd2;
    localparam logic [ALU_OP_W-1:0] ALU_EOR = 2'd3;

    localparam int CARRY_W = 2;
    localparam logic [CARRY_W-1:0] CARRY_ZERO = 2'd0;
    localparam logic [CARRY_W-1:0] CARRY_ONE  = 2'd1;
    localparam logic [CARRY_W-1:0] CARRY_FLAG = 2'd2;

    localparam int SRC_W = 2;
    localparam logic [SRC_W-1:0] SRC_A    = 2'd0;
    localparam logic [SRC_W-1:0] SRC_X    = 2'd1;
    localparam logic [SRC_W-1:0] SRC_ZERO = 2'd2;

    localparam int DST_W = 2;
    localparam logic [DST_W-1:0] DST_NONE = 2'd0;
    localparam logic [DST_W-1:0] DST_A    = 2'd1;
    localparam logic [DST_W-1:0] DST_X    = 2'd2;

    localparam int ASEL_W = 2;
    localparam logic [ASEL_W-1:0] ASEL_PC  = 2'd0;
    localparam logic [ASEL_W-1:0] ASEL_ZPG = 2'd1;
    localparam logic [ASEL_W-1:0] ASEL_ABS = 2'd2;
    localparam logic [ASEL_W-1:0] ASEL_VEC = 2'd3;

    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] T_BOOT0   = 3'd0;
    localparam logic [STATE_W-1:0] T_BOOT1   = 3'd1;
    localparam logic [STATE_W-1:0] T0_FETCH  = 3'd2;
    localparam logic [STATE_W-1:0] T1_DECODE = 3'd3;
    localparam logic [STATE_W-1:0] T2_OPER   = 3'd4;
    localparam logic [STATE_W-1:0] T3_ABS    = 3'd5;
    localparam logic [STATE_W-1:0] T_JAM     = 3'd7;

endpackage

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic [DATA_W-1:0]   i_a,
    input  logic [DATA_W-1:0]   i_b,
    input  logic                i_ci,
    input  logic                i_b_inv,
    input  logic [ALU_OP_W-1:0] i_op,
    output logic [DATA_W-1:0]   o_out,
    output logic                o_co
);

    logic [DATA_W-1:0] b;
    logic [DATA_W:0]   sum;

    assign b   = i_b_inv ? ~i_b : i_b; // sbc, and dex via x + ff
    assign sum = {1'b0, i_a} + {1'b0, b} + {{DATA_W{1'b0}}, i_ci};

    always_comb begin
        o_co = 1'b0; // only the adder produces a carry
        case (i_op)
            ALU_AND: o_out = i_a & b;
            ALU_ORA: o_out = i_a | b;
            ALU_EOR: o_out = i_a ^ b;
            default: begin
                o_out = sum[DATA_W-1:0];
                o_co  = sum[DATA_W];
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/10ps
`default_nettype none

module decode import cpu_pkg::*; (
    input  opcode_u               i_opcode,
    output logic [MODE_W-1:0]     o_mode,
    output logic                  o_store,
    output logic [ALU_OP_W-1:0]   o_alu_op,
    output logic                  o_b_inv,
    output logic [CARRY_W-1:0]    o_carry_sel,
    output logic [SRC_W-1:0]      o_src,
    output logic [DST_W-1:0]      o_dst,
    output logic                  o_set_c,
    output logic                  o_clr_c,
    output logic                  o_c_from_alu
);

    always_comb begin
        o_mode       = MODE_BAD;
        o_store      = 1'b0;
        o_alu_op     = ALU_ADD;
        o_b_inv      = 1'b0;
        o_carry_sel  = CARRY_ZERO;
        o_src        = SRC_ZERO; // loads pass the memory byte through the adder
        o_dst        = DST_NONE;
        o_set_c      = 1'b0;
        o_clr_c      = 1'b0;
        o_c_from_alu = 1'b0;

        case (i_opcode.raw)
            OP_JMP_ABS: o_mode = MODE_JMP;
            OP_TAX: begin
                o_mode = MODE_IMP;
                o_src  = SRC_A;
                o_dst  = DST_X;
            end
            OP_TXA: begin
                o_mode = MODE_IMP;
                o_src  = SRC_X;
                o_dst  = DST_A;
            end
            OP_INX: begin
                o_mode      = MODE_IMP;
                o_src       = SRC_X;
                o_dst       = DST_X;
                o_carry_sel = CARRY_ONE; // x + 0 + 1
            end
            OP_DEX: begin
                o_mode  = MODE_IMP;
                o_src   = SRC_X;
                o_dst   = DST_X;
                o_b_inv = 1'b1; // x + ff
            end
            OP_CLC: begin
                o_mode  = MODE_IMP;
                o_clr_c = 1'b1;
            end
            OP_SEC: begin
                o_mode  = MODE_IMP;
                o_set_c = 1'b1;
            end
            OP_NOP: o_mode = MODE_IMP;
            default: begin
                if (i_opcode.f.cc == CC_ALU) begin
                    case (i_opcode.f.bbb)
                        BBB_ZPG: o_mode = MODE_ZPG;
                        BBB_IMM: o_mode = MODE_IMM;
                        BBB_ABS: o_mode = MODE_ABS;
                        default: o_mode = MODE_BAD;
                    endcase
                    o_src = SRC_A;
                    o_dst = DST_A;
                    case (i_opcode.f.aaa)
                        AAA_ORA: o_alu_op = ALU_ORA;
                        AAA_AND: o_alu_op = ALU_AND;
                        AAA_EOR: o_alu_op = ALU_EOR;
                        AAA_ADC: begin
                            o_carry_sel  = CARRY_FLAG;
                            o_c_from_alu = 1'b1;
                        end
                        AAA_SBC: begin
                            o_b_inv      = 1'b1;
                            o_carry_sel  = CARRY_FLAG;
                            o_c_from_alu = 1'b1;
                        end
                        AAA_ST: begin
                            o_store = 1'b1;
                            o_dst   = DST_NONE;
                            if (i_opcode.f.bbb == BBB_IMM) o_mode = MODE_BAD; // no sta #
                        end
                        AAA_LD: o_src = SRC_ZERO;
                        default: o_mode = MODE_BAD; // cmp not kept
                    endcase
                end else if (i_opcode.f.cc == CC_X) begin
                    case (i_opcode.f.bbb)
                        BBB_IMM_X: o_mode = (i_opcode.f.aaa == AAA_LD) ? MODE_IMM : MODE_BAD;
                        BBB_ZPG:   o_mode = MODE_ZPG;
                        BBB_ABS:   o_mode = MODE_ABS;
                        default:   o_mode = MODE_BAD;
                    endcase
                    case (i_opcode.f.aaa)
                        AAA_ST: begin
                            o_store = 1'b1;
                            o_src   = SRC_X;
                        end
                        AAA_LD:  o_dst  = DST_X;
                        default: o_mode = MODE_BAD;
                    endcase
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module sequencer import cpu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_ready,
    input  logic [MODE_W-1:0] i_mode,
    input  logic              i_store,
    output logic [ASEL_W-1:0] o_addr_sel,
    output logic              o_ir_en,
    output logic              o_lo_en,
    output logic              o_pc_inc,
    output logic              o_pc_load,
    output logic              o_exec,
    output logic              o_write,
    output logic              o_sync,
    output logic              o_jam
);

    logic [STATE_W-1:0] state;
    logic [STATE_W-1:0] state_nx;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= T_BOOT0;
        end else if (i_ready) begin // a stall stretches the current cycle
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx   = state;
        o_addr_sel = ASEL_PC;
        o_ir_en    = 1'b0;
        o_lo_en    = 1'b0;
        o_pc_inc   = 1'b0;
        o_pc_load  = 1'b0;
        o_exec     = 1'b0;
        o_write    = 1'b0;
        o_sync     = 1'b0;
        o_jam      = 1'b0;

        case (state)
            T_BOOT0: begin
                o_addr_sel = ASEL_VEC;
                o_lo_en    = i_ready; // vector low byte
                state_nx   = T_BOOT1;
            end
            T_BOOT1: begin
                o_pc_load = i_ready; // pc sits on the vector high byte here
                state_nx  = T0_FETCH;
            end
            T0_FETCH: begin
                o_sync   = 1'b1;
                o_ir_en  = i_ready;
                o_pc_inc = i_ready;
                state_nx = T1_DECODE;
            end
            T1_DECODE: begin
                state_nx = T0_FETCH;
                case (i_mode)
                    MODE_IMP: o_exec = i_ready;
                    MODE_IMM: begin
                        o_exec   = i_ready;
                        o_pc_inc = i_ready;
                    end
                    MODE_ZPG, MODE_ABS, MODE_JMP: begin
                        o_lo_en  = i_ready; // first operand byte
                        o_pc_inc = i_ready;
                        state_nx = T2_OPER;
                    end
                    default: state_nx = T_JAM;
                endcase
            end
            T2_OPER: begin
                state_nx = T0_FETCH;
                case (i_mode)
                    MODE_ZPG: begin
                        o_addr_sel = ASEL_ZPG;
                        o_exec     = i_ready & ~i_store;
                        o_write    = i_ready & i_store;
                    end
                    MODE_ABS: begin
                        o_lo_en  = i_ready; // high byte, low byte moves down
                        o_pc_inc = i_ready;
                        state_nx = T3_ABS;
                    end
                    MODE_JMP: o_pc_load = i_ready;
                    default:  state_nx  = T_JAM;
                endcase
            end
            T3_ABS: begin
                o_addr_sel = ASEL_ABS;
                o_exec     = i_ready & ~i_store;
                o_write    = i_ready & i_store;
                state_nx   = T0_FETCH;
            end
            default: begin
                o_jam    = 1'b1; // halted until reset
                state_nx = T_JAM;
            end
        endcase
    end

    a_no_write_when_jammed: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_write && o_jam));

    a_jam_is_final: assert property (@(posedge i_clk) disable iff (i_rst)
        state == T_JAM |=> state == T_JAM);

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath import cpu_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [DATA_W-1:0]   i_data,
    input  logic [MODE_W-1:0]   i_mode,
    input  logic                i_store,
    input  logic [ALU_OP_W-1:0] i_alu_op,
    input  logic                i_b_inv,
    input  logic [CARRY_W-1:0]  i_carry_sel,
    input  logic [SRC_W-1:0]    i_src,
    input  logic [DST_W-1:0]    i_dst,
    input  logic                i_set_c,
    input  logic                i_clr_c,
    input  logic                i_c_from_alu,
    input  logic [ASEL_W-1:0]   i_addr_sel,
    input  logic                i_ir_en,
    input  logic                i_lo_en,
    input  logic                i_pc_inc,
    input  logic                i_pc_load,
    input  logic                i_exec,
    input  logic                i_write,
    input  logic                i_sync,
    output opcode_u             o_opcode,
    output logic [ADDR_W-1:0]   o_addr,
    output logic                o_rw,
    output logic [DATA_W-1:0]   o_dout
);

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] x;
    logic              c;
    logic [ADDR_W-1:0] pc;
    opcode_u           ir;
    logic [ADDR_W-1:0] opnd; // operand bytes enter at the top and shift down
    logic [DATA_W-1:0] sb;
    logic [DATA_W-1:0] db;
    logic [DATA_W-1:0] alu_out;
    logic              alu_ci;
    logic              alu_co;

    always_comb o_opcode.raw = i_sync ? i_data : ir.raw;

    always_comb begin
        case (i_src)
            SRC_A:   sb = a;
            SRC_X:   sb = x;
            default: sb = '0;
        endcase
        case (i_carry_sel)
            CARRY_ONE:  alu_ci = 1'b1;
            CARRY_FLAG: alu_ci = c;
            default:    alu_ci = 1'b0;
        endcase
        case (i_addr_sel)
            ASEL_ZPG: o_addr = {8'h00, opnd[ADDR_W-1:DATA_W]};
            ASEL_ABS: o_addr = opnd;
            ASEL_VEC: o_addr = RST_VECTOR;
            default:  o_addr = pc;
        endcase
    end

    assign db     = (i_mode == MODE_IMP) ? '0 : i_data; // implied ops ignore the bus
    assign o_rw   = !(i_store && (i_addr_sel == ASEL_ZPG || i_addr_sel == ASEL_ABS));
    assign o_dout = o_rw ? '0 : sb;

    alu u_alu (
        .i_a     (sb),
        .i_b     (db),
        .i_ci    (alu_ci),
        .i_b_inv (i_b_inv),
        .i_op    (i_alu_op),
        .o_out   (alu_out),
        .o_co    (alu_co)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= RST_VECTOR + 16'd1; // boot1 reads the vector high byte through pc
        end else if (i_pc_load) begin
            pc <= {i_data, opnd[ADDR_W-1:DATA_W]};
        end else if (i_pc_inc) begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ir_en) ir.raw <= i_data;
        if (i_lo_en) opnd <= {i_data, opnd[ADDR_W-1:DATA_W]};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a <= '0;
            x <= '0;
            c <= 1'b0;
        end else if (i_exec) begin
            if (i_dst == DST_A) a <= alu_out;
            if (i_dst == DST_X) x <= alu_out;
            if (i_set_c) begin
                c <= 1'b1;
            end else if (i_clr_c) begin
                c <= 1'b0;
            end else if (i_c_from_alu) begin
                c <= alu_co; // adc and sbc
            end
        end
    end

    a_dout_idle_on_read: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rw |-> o_dout == '0);

    // the sequencer's write strobe must land on a cycle the bus shows as a write
    a_write_on_write_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_write |-> !o_rw);

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_ready,
    output logic [ADDR_W-1:0] o_addr,
    output logic              o_rw,
    output logic [DATA_W-1:0] o_dout,
    output logic              o_sync,
    output logic              o_jam
);

    opcode_u               opcode;
    logic [MODE_W-1:0]     mode;
    logic                  store;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  b_inv;
    logic [CARRY_W-1:0]    carry_sel;
    logic [SRC_W-1:0]      src;
    logic [DST_W-1:0]      dst;
    logic                  set_c;
    logic                  clr_c;
    logic                  c_from_alu;
    logic [ASEL_W-1:0]     addr_sel;
    logic                  ir_en;
    logic                  lo_en;
    logic                  pc_inc;
    logic                  pc_load;
    logic                  exec;
    logic                  write;

    decode u_decode (
        .i_opcode     (opcode),
        .o_mode       (mode),
        .o_store      (store),
        .o_alu_op     (alu_op),
        .o_b_inv      (b_inv),
        .o_carry_sel  (carry_sel),
        .o_src        (src),
        .o_dst        (dst),
        .o_set_c      (set_c),
        .o_clr_c      (clr_c),
        .o_c_from_alu (c_from_alu)
    );

    sequencer u_sequencer (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ready    (i_ready),
        .i_mode     (mode),
        .i_store    (store),
        .o_addr_sel (addr_sel),
        .o_ir_en    (ir_en),
        .o_lo_en    (lo_en),
        .o_pc_inc   (pc_inc),
        .o_pc_load  (pc_load),
        .o_exec     (exec),
        .o_write    (write),
        .o_sync     (o_sync),
        .o_jam      (o_jam)
    );

    datapath u_datapath (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_data       (i_data),
        .i_mode       (mode),
        .i_store      (store),
        .i_alu_op     (alu_op),
        .i_b_inv      (b_inv),
        .i_carry_sel  (carry_sel),
        .i_src        (src),
        .i_dst        (dst),
        .i_set_c      (set_c),
        .i_clr_c      (clr_c),
        .i_c_from_alu (c_from_alu),
        .i_addr_sel   (addr_sel),
        .i_ir_en      (ir_en),
        .i_lo_en      (lo_en),
        .i_pc_inc     (pc_inc),
        .i_pc_load    (pc_load),
        .i_exec       (exec),
        .i_write      (write),
        .i_sync       (o_sync),
        .o_opcode     (opcode),
        .o_addr       (o_addr),
        .o_rw         (o_rw),
        .o_dout       (o_dout)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic o_clk
);

    localparam int HALF_NS = 20; // 40 ns period

    initial o_clk = 1'b0;

    always #(HALF_NS) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* verification/tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    localparam int CLK_NS    = 40;
    localparam int NUM_STEPS = 80; // generator loop passes
    localparam logic [7:0] OP_JMP = 8'h4c;
    localparam logic [7:0] OP_CLC = 8'h18;
    localparam logic [7:0] OP_SEC = 8'h38;
    localparam logic [7:0] OP_JAM = 8'h02;

    logic        clk;
    logic        rst;
    logic        ready;
    logic [7:0]  rd_data;
    logic [15:0] addr;
    logic        rw;
    logic [7:0]  wr_data;
    logic        sync;
    logic        jam;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535]; // model's own view of memory
    logic [15:0] exp_sync[$];
    logic [15:0] exp_wr_addr[$];
    logic [7:0]  exp_wr_data[$];
    logic [15:0] start_pc;
    integer      seed;
    int          sync_idx;
    int          wr_idx;
    int          watch_ns;
    logic        model_ready;
    logic        rst_d;
    logic        jam_seen;

    tb_clock u_clock (.o_clk(clk));

    cpu_core DUT (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_data  (rd_data),
        .i_ready (ready),
        .o_addr  (addr),
        .o_rw    (rw),
        .o_dout  (wr_data),
        .o_sync  (sync),
        .o_jam   (jam)
    );

    assign rd_data = mem[addr]; // same-cycle read

    always @(posedge clk) begin
        if (ready && !rw) mem[addr] <= wr_data;
    end

    always @(negedge clk) begin
        ready <= ($random(seed) & 3) != 0; // about one cycle in four stalls
    end

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] op_at(input int idx);
        case (idx)
            0:       return 8'ha9;
            1:       return 8'ha2;
            2:       return 8'h09;
            3:       return 8'h29;
            4:       return 8'h49;
            5:       return 8'h69;
            6:       return 8'he9;
            7:       return 8'ha5;
            8:       return 8'ha6;
            9:       return 8'h05;
            10:      return 8'h25;
            11:      return 8'h45;
            12:      return 8'h65;
            13:      return 8'he5;
            14:      return 8'h85;
            15:      return 8'h86;
            16:      return 8'had;
            17:      return 8'hae;
            18:      return 8'h0d;
            19:      return 8'h2d;
            20:      return 8'h4d;
            21:      return 8'h6d;
            22:      return 8'hed;
            23:      return 8'h8d;
            24:      return 8'h8e;
            25:      return 8'haa;
            26:      return 8'h8a;
            27:      return 8'he8;
            28:      return 8'hca;
            29:      return 8'h18;
            30:      return 8'h38;
            default: return 8'hea;
        endcase
    endfunction

    task automatic put_byte(inout logic [15:0] at, input logic [7:0] b);
        mem[at] = b;
        at = at + 16'd1;
    endtask

    // 0..6 immediate, 7..15 zero page, 16..24 absolute, rest implied
    task automatic emit_op(inout logic [15:0] gp, input int idx);
        logic [7:0] lo;
        lo = $random(seed);
        put_byte(gp, op_at(idx));
        if (idx < 16) begin
            put_byte(gp, lo);
        end else if (idx < 25) begin
            put_byte(gp, lo);
            put_byte(gp, 8'h20); // data page
        end
    endtask

    task automatic gen_program();
        logic [15:0] gp;
        logic [15:0] tgt;
        int          n;
        int          r;
        int          st;
        for (n = 0; n < 65536; n++) mem[n] = $random(seed);
        start_pc = 16'h0400 + ($random(seed) & 16'h00ff);
        mem[16'hfffc] = start_pc[7:0];
        mem[16'hfffd] = start_pc[15:8];
        gp = start_pc;
        // x wraps up to 00, then back down to ff
        put_byte(gp, 8'ha2);
        put_byte(gp, 8'hff);
        put_byte(gp, 8'he8);
        put_byte(gp, 8'h86);
        put_byte(gp, 8'h10);
        put_byte(gp, 8'hca);
        put_byte(gp, 8'h8e);
        put_byte(gp, 8'h00);
        put_byte(gp, 8'h20);
        for (n = 0; n < NUM_STEPS; n++) begin
            r = $random(seed) & 7;
            if (r == 0) begin
                tgt = gp + 3 + ($random(seed) & 15); // skip a short gap
                put_byte(gp, OP_JMP);
                put_byte(gp, tgt[7:0]);
                put_byte(gp, tgt[15:8]);
                gp = tgt;
            end else begin
                if (r == 1) put_byte(gp, ($random(seed) & 1) ? OP_SEC : OP_CLC);
                emit_op(gp, $random(seed) & 31);
                if (r >= 4) begin
                    st = $random(seed) & 3;
                    emit_op(gp, (st < 2) ? 14 + st : 21 + st); // sta or stx
                end
            end
        end
        put_byte(gp, OP_JAM);
    endtask

    // instruction-level model of the kept 6502 subset
    function automatic void run_model(input logic [15:0] start);
        logic [15:0] pc;
        logic [15:0] ea;
        logic [7:0]  op;
        logic [7:0]  m;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [8:0]  sum;
        logic        c;
        logic        halted;
        pc = start;
        a = 8'h00;
        x = 8'h00;
        c = 1'b0;
        halted = 1'b0;
        while (!halted && exp_sync.size() < 4096) begin
            op = ref_mem[pc];
            exp_sync.push_back(pc);
            ea = {8'h00, ref_mem[pc + 16'd1]};
            m = ref_mem[pc + 16'd1]; // immediate value
            case (op)
                8'ha9, 8'ha2, 8'h09, 8'h29, 8'h49, 8'h69, 8'he9: pc = pc + 16'd2;
                8'ha5, 8'ha6, 8'h05, 8'h25, 8'h45, 8'h65, 8'he5, 8'h85, 8'h86: begin
                    m = ref_mem[ea];
                    pc = pc + 16'd2;
                end
                8'had, 8'hae, 8'h0d, 8'h2d, 8'h4d, 8'h6d, 8'hed, 8'h8d, 8'h8e: begin
                    ea = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
                    m = ref_mem[ea];
                    pc = pc + 16'd3;
                end
                8'h4c: pc = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
                8'haa, 8'h8a, 8'he8, 8'hca, 8'h18, 8'h38, 8'hea: pc = pc + 16'd1;
                default: halted = 1'b1;
            endcase
            case (op)
                8'ha9, 8'ha5, 8'had: a = m;
                8'ha2, 8'ha6, 8'hae: x = m;
                8'h09, 8'h05, 8'h0d: a = a | m;
                8'h29, 8'h25, 8'h2d: a = a & m;
                8'h49, 8'h45, 8'h4d: a = a ^ m;
                8'h69, 8'h65, 8'h6d: begin
                    sum = {1'b0, a} + {1'b0, m} + {8'h00, c};
                    a = sum[7:0];
                    c = sum[8];
                end
                8'he9, 8'he5, 8'hed: begin
                    sum = {1'b0, a} - {1'b0, m} - {8'h00, !c}; // borrow is not carry
                    a = sum[7:0];
                    c = !sum[8];
                end
                8'h85, 8'h8d: begin
                    ref_mem[ea] = a;
                    exp_wr_addr.push_back(ea);
                    exp_wr_data.push_back(a);
                end
                8'h86, 8'h8e: begin
                    ref_mem[ea] = x;
                    exp_wr_addr.push_back(ea);
                    exp_wr_data.push_back(x);
                end
                8'haa: x = a;
                8'h8a: a = x;
                8'he8: x = x + 8'd1;
                8'hca: x = x - 8'd1;
                8'h18: c = 1'b0;
                8'h38: c = 1'b1;
                default: ;
            endcase
        end
    endfunction

    always @(posedge clk) begin
        rst_d <= rst;
        if (rst_d) begin // reset and the cycle after it
            check("o_sync", sync, 1'b0);
            check("o_jam", jam, 1'b0);
            check("o_rw", rw, 1'b1);
        end
        if (!rst) begin
            if (jam_seen && !jam) abort_run("o_jam dropped without a reset");
            if (jam_seen && (sync || !rw)) abort_run("bus activity after the core jammed");
            if (ready && sync) begin
                if (sync_idx >= exp_sync.size()) begin
                    abort_run("more opcode fetches than the model expects");
                end else begin
                    check("o_addr at sync", addr, exp_sync[sync_idx]);
                    sync_idx++;
                end
            end
            if (ready && !rw) begin
                if (wr_idx >= exp_wr_addr.size()) begin
                    abort_run("more writes than the model expects");
                end else begin
                    check("o_addr at write", addr, exp_wr_addr[wr_idx]);
                    check("o_dout", wr_data, exp_wr_data[wr_idx]);
                    wr_idx++;
                end
            end
            if (jam) jam_seen <= 1'b1;
        end
    end

    initial begin
        wait (model_ready);
        #(watch_ns);
        abort_run("timeout, the core never reached the jam state");
    end

    initial begin
        seed = 57913;
        rst = 1'b1;
        ready = 1'b0;
        rst_d = 1'b0;
        jam_seen = 1'b0;
        sync_idx = 0;
        wr_idx = 0;
        model_ready = 1'b0;
        gen_program();
        for (int i = 0; i < 65536; i++) ref_mem[i] = mem[i];
        run_model({ref_mem[16'hfffd], ref_mem[16'hfffc]});
        watch_ns = (exp_sync.size() * 4 * 4 + 64) * CLK_NS; // stall margin of 4
        model_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (jam === 1'b1);
        repeat (20) @(posedge clk); // core must stay quiet while jammed
        check("sync count", sync_idx, exp_sync.size());
        check("write count", wr_idx, exp_wr_addr.size());
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cpu_pkg.sv
hw/alu.sv
hw/decode.sv
hw/sequencer.sv
hw/datapath.sv
hw/cpu_core.sv
verification/tb_clock.sv
verification/tb_cpu.sv
